// File: design/usb_fs_defines.svh
// timing values assume a 60 MHz clock with exactly 5 clocks per full-speed bit
`ifndef USB_FS_DEFINES_SVH
`define USB_FS_DEFINES_SVH

// bit timing on the 60 MHz clock
`define USB_CLKS_PER_BIT           5           // 12 Mb/s from 60 MHz
`define USB_SE0_RESET_CYCLES       300         // 5 us of SE0 means host bus reset
`define USB_SYNC_BITS              8           // KJKJKJKK
`define USB_CONNECT_CYCLES_DEFAULT 120000000   // 2 s before the pull-up goes on

// crc generators and the remainders left by a good packet
`define USB_CRC5_POLY              5'b00101    // x^5 + x^2 + 1
`define USB_CRC16_POLY             16'h8005    // x^16 + x^15 + x^2 + 1
`define USB_CRC5_RESIDUE           5'b01100
`define USB_CRC16_RESIDUE          16'h800D

`define USB_ADDR_W                 11          // 7 bit address + 4 bit endpoint

`endif

// File: design/usb_pid_pkg.sv
// PID codes hold only the low nibble and the complement nibble is checked by the receiver
`default_nettype none

package usb_pid_pkg;

    typedef enum logic [3:0] {
        PID_OUT   = 4'b0001,
        PID_IN    = 4'b1001,
        PID_SOF   = 4'b0101,
        PID_SETUP = 4'b1101,
        PID_DATA0 = 4'b0011,
        PID_DATA1 = 4'b1011,
        PID_ACK   = 4'b0010,
        PID_NAK   = 4'b1010,
        PID_STALL = 4'b1110
    } usb_pid_t;

    // encoded as the two low PID bits
    typedef enum logic [1:0] {
        PKT_OTHER     = 2'b00,
        PKT_TOKEN     = 2'b01,
        PKT_HANDSHAKE = 2'b10,
        PKT_DATA      = 2'b11
    } usb_pkt_kind_t;

    function automatic usb_pkt_kind_t usb_pkt_kind(input usb_pid_t pid);
        return usb_pkt_kind_t'(pid[1:0]);
    endfunction

endpackage

`default_nettype wire

// File: design/usb_line_pkg.sv
// line states are coded as {dp, dn} for full speed where J has D+ high
`default_nettype none

package usb_line_pkg;

    typedef enum logic [1:0] {
        LINE_SE0 = 2'b00,
        LINE_K   = 2'b01,
        LINE_J   = 2'b10,
        LINE_SE1 = 2'b11     // illegal on a healthy bus
    } usb_line_t;

    typedef enum logic [1:0] {
        RX_IDLE,             // waiting for the first K of sync
        RX_SYNC,             // counting sync zeros
        RX_DATA,             // packet bits
        RX_EOP               // first SE0 bit seen
    } usb_rx_state_t;

endpackage

`default_nettype wire

// File: design/usb_bit_if.sv
// single-cycle strobes with no back-pressure and bit_val only meaningful with ena
`timescale 1ns/10ps
`default_nettype none

interface usb_bit_if;

    logic sta;       // full sync seen
    logic ena;       // one unstuffed data bit
    logic bit_val;   // decoded bit
    logic fin;       // eop or stuffing error

    modport src (output sta, ena, bit_val, fin);
    modport dst (input  sta, ena, bit_val, fin);

endinterface

`default_nettype wire

// File: design/usb_byte_if.sv
// single-cycle strobes with no back-pressure while pid and pid_ok hold between packets
`timescale 1ns/10ps
`default_nettype none

interface usb_byte_if import usb_pid_pkg::*; ();

    logic     sta;        // pid byte complete
    usb_pid_t pid;        // held until next sta
    logic     pid_ok;     // complement check
    logic     byte_en;    // one byte after the pid
    logic [7:0] byte_val; // valid with byte_en
    logic     fin;        // end of packet

    modport src (output sta, pid, pid_ok, byte_en, byte_val, fin);
    modport dst (input  sta, pid, pid_ok, byte_en, byte_val, fin);

endinterface

`default_nettype wire

// File: design/usb_connect_ctrl.sv
// dp and dn must already be synchronous to clk and the connect delay restarts on every rstn
`timescale 1ns/10ps
`default_nettype none
`include "usb_fs_defines.svh"

module usb_connect_ctrl import usb_line_pkg::*; #(
    parameter int CONNECT_CYCLES = `USB_CONNECT_CYCLES_DEFAULT
) (
    input  wire  clk,
    input  wire  rstn,
    input  wire  usb_dp_rx,
    input  wire  usb_dn_rx,
    output logic usb_dp_pull,
    output logic usb_rstn
);

    localparam int CNT_TOP = CONNECT_CYCLES + `USB_SE0_RESET_CYCLES;
    localparam int CNT_W   = $clog2(CNT_TOP + 1);

    usb_line_t        line;
    logic [CNT_W-1:0] cnt;   // connect delay then se0 countdown

    assign line = usb_line_t'({usb_dp_rx, usb_dn_rx});

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            usb_dp_pull <= 1'b0;
            usb_rstn    <= 1'b0;
            cnt         <= '0;
        end else if (cnt < CNT_W'(CONNECT_CYCLES)) begin
            usb_dp_pull <= 1'b0;                       // still unplugged
            usb_rstn    <= 1'b0;
            cnt         <= cnt + 1'b1;
        end else if (line == LINE_J || line == LINE_K) begin
            usb_dp_pull <= 1'b1;
            usb_rstn    <= 1'b1;
            cnt         <= CNT_W'(CNT_TOP);            // rearm se0 timer
        end else if (cnt > CNT_W'(CONNECT_CYCLES)) begin
            usb_dp_pull <= 1'b1;
            cnt         <= cnt - 1'b1;                 // se0 held so far
        end else begin
            usb_dp_pull <= 1'b1;
            usb_rstn    <= 1'b0;                       // host bus reset
        end
    end

endmodule

`default_nettype wire

// File: design/usb_line_rx.sv
// expects a host clock within a few percent of 12 MHz and re-centres on every line transition
`timescale 1ns/10ps
`default_nettype none
`include "usb_fs_defines.svh"

module usb_line_rx import usb_line_pkg::*; (
    input  wire    clk,
    input  wire    rstn,
    input  wire    usb_dp_rx,
    input  wire    usb_dn_rx,
    usb_bit_if.src bits
);

    localparam int PH_W       = $clog2(`USB_CLKS_PER_BIT);
    localparam int PH_LAST    = `USB_CLKS_PER_BIT - 1;
    localparam int PH_MID     = `USB_CLKS_PER_BIT / 2;
    localparam int SYNC_ZEROS = `USB_SYNC_BITS - 1;

    logic [1:0]      dp_sr;       // two-flop synchronisers
    logic [1:0]      dn_sr;
    usb_line_t       line;
    usb_line_t       line_d;
    usb_line_t       last_smp;    // previous mid-bit sample
    logic [PH_W-1:0] ph;          // position inside the bit
    logic            trans;
    logic            smp;
    logic            nrzi;        // decoded bit of this sample
    usb_rx_state_t   state;
    logic [2:0]      run;         // sync zeros or data ones

    assign line  = usb_line_t'({dp_sr[1], dn_sr[1]});
    assign trans = (line != line_d);
    assign smp   = (ph == PH_W'(PH_MID)) && !trans;
    assign nrzi  = (line == last_smp);                 // no change means 1

    // --------------------------------------------------
    // sampling and bit-phase recovery
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            dp_sr  <= 2'b11;                           // idle J
            dn_sr  <= 2'b00;
            line_d <= LINE_J;
            ph     <= '0;
        end else begin
            dp_sr  <= {dp_sr[0], usb_dp_rx};
            dn_sr  <= {dn_sr[0], usb_dn_rx};
            line_d <= line;
            if (trans)
                ph <= PH_W'(1);                        // edge is phase 0
            else if (ph == PH_W'(PH_LAST))
                ph <= '0;
            else
                ph <= ph + 1'b1;
        end
    end

    // --------------------------------------------------
    // sync, nrzi, unstuffing and eop
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= RX_IDLE;
            run      <= '0;
            last_smp <= LINE_J;
            bits.sta <= 1'b0;
            bits.ena <= 1'b0;
            bits.fin <= 1'b0;
        end else begin
            bits.sta <= 1'b0;
            bits.ena <= 1'b0;
            bits.fin <= 1'b0;
            if (smp) begin
                last_smp <= line;
                case (state)
                    RX_IDLE: begin
                        if (line == LINE_K && last_smp == LINE_J) begin
                            state <= RX_SYNC;
                            run   <= 3'd1;                 // first sync zero
                        end
                    end
                    RX_SYNC: begin
                        if (line == LINE_SE0 || line == LINE_SE1) begin
                            state <= RX_IDLE;
                        end else if (!nrzi) begin
                            if (run != 3'(SYNC_ZEROS))
                                run <= run + 1'b1;
                        end else if (run == 3'(SYNC_ZEROS)) begin
                            bits.sta <= 1'b1;
                            state    <= RX_DATA;
                            run      <= 3'd1;              // closing K counts for stuffing
                        end else begin
                            state <= RX_IDLE;              // short sync
                        end
                    end
                    RX_DATA: begin
                        if (line == LINE_SE0) begin
                            state <= RX_EOP;
                        end else if (line == LINE_SE1) begin
                            bits.fin <= 1'b1;
                            state    <= RX_IDLE;
                        end else if (run == 3'd6) begin
                            run <= '0;                     // stuffed zero dropped
                            if (nrzi) begin
                                bits.fin <= 1'b1;          // seventh one aborts
                                state    <= RX_IDLE;
                            end
                        end else begin
                            bits.ena <= 1'b1;
                            run      <= nrzi ? run + 1'b1 : 3'd0;
                        end
                    end
                    RX_EOP: begin
                        bits.fin <= 1'b1;                  // second eop bit time
                        state    <= RX_IDLE;
                    end
                    default: state <= RX_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (smp)
            bits.bit_val <= nrzi;
    end

endmodule

`default_nettype wire

// File: design/usb_packet_rx.sv
// bits arrive LSB first and a packet that ends off a byte boundary is flagged through pid_ok
`timescale 1ns/10ps
`default_nettype none

module usb_packet_rx import usb_pid_pkg::*; (
    input  wire     clk,
    input  wire     rstn,
    usb_bit_if.dst  bits,
    usb_byte_if.src bytes
);

    logic [7:0] sh;         // byte being assembled
    logic [7:0] nxt;        // sh with the incoming bit
    logic [2:0] cnt;        // bits in current byte
    logic       pid_wait;   // first byte still due
    logic       byte_done;

    assign nxt       = {bits.bit_val, sh[7:1]};
    assign byte_done = bits.ena && (cnt == 3'd7);

    // --------------------------------------------------
    // byte assembly
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (bits.ena)
            sh <= nxt;
        if (byte_done && pid_wait)
            bytes.pid <= usb_pid_t'(nxt[3:0]);
        if (byte_done && !pid_wait)
            bytes.byte_val <= nxt;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cnt           <= '0;
            pid_wait      <= 1'b0;
            bytes.sta     <= 1'b0;
            bytes.pid_ok  <= 1'b0;
            bytes.byte_en <= 1'b0;
            bytes.fin     <= 1'b0;
        end else begin
            bytes.sta     <= 1'b0;
            bytes.byte_en <= 1'b0;
            bytes.fin     <= bits.fin;
            if (bits.sta) begin
                cnt      <= '0;
                pid_wait <= 1'b1;
            end else if (bits.ena) begin
                cnt <= cnt + 1'b1;                     // wraps every byte
                if (byte_done && pid_wait) begin
                    bytes.sta    <= 1'b1;
                    bytes.pid_ok <= (nxt[3:0] == ~nxt[7:4]);
                    pid_wait     <= 1'b0;
                end else if (byte_done) begin
                    bytes.byte_en <= 1'b1;
                end
            end
            if (bits.fin && (cnt != 3'd0 || pid_wait))
                bytes.pid_ok <= 1'b0;                  // partial byte or no pid
        end
    end

endmodule

`default_nettype wire

// File: design/usb_packet_check.sv
// rp_addr is only meaningful for token packets and byte counts saturate above two
`timescale 1ns/10ps
`default_nettype none
`include "usb_fs_defines.svh"

module usb_packet_check import usb_pid_pkg::*; (
    input  wire                    clk,
    input  wire                    rstn,
    usb_byte_if.dst                bytes,
    output usb_pid_t               rp_pid,
    output logic [`USB_ADDR_W-1:0] rp_addr,
    output logic                   rp_byte_en,
    output logic [7:0]             rp_byte,
    output logic                   rp_fin,
    output logic                   rp_okay
);

    logic [4:0]             crc5;
    logic [15:0]            crc16;
    logic [4:0]             crc5_nxt;
    logic [15:0]            crc16_nxt;
    logic [`USB_ADDR_W-1:0] tok;       // address and endpoint
    logic [1:0]             nbytes;    // 3 means more than two
    usb_pkt_kind_t          kind;
    logic                   kind_ok;

    // serial crc over one byte LSB first with register width w
    function automatic logic [15:0] crc_byte(input logic [15:0] crc,
                                             input logic [15:0] poly,
                                             input int unsigned w,
                                             input logic [7:0]  d);
        logic [15:0] c;
        logic        fb;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            fb = c[w-1] ^ d[i];
            c  = (c << 1) ^ (fb ? poly : 16'h0000);
        end
        return c & ((16'h0001 << w) - 16'h0001);   // mask wraps to all ones at 16
    endfunction

    assign crc5_nxt  = 5'(crc_byte({11'h000, crc5}, {11'h000, `USB_CRC5_POLY}, 5,
                                   bytes.byte_val));
    assign crc16_nxt = crc_byte(crc16, `USB_CRC16_POLY, 16, bytes.byte_val);
    assign kind      = usb_pkt_kind(bytes.pid);

    always_comb begin
        case (kind)
            PKT_TOKEN:     kind_ok = (nbytes == 2'd2) && (crc5 == `USB_CRC5_RESIDUE);
            PKT_DATA:      kind_ok = (nbytes >= 2'd2) && (crc16 == `USB_CRC16_RESIDUE);
            PKT_HANDSHAKE: kind_ok = (nbytes == 2'd0);
            default:       kind_ok = 1'b0;
        endcase
    end

    // --------------------------------------------------
    // crc and field capture
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (bytes.sta) begin
            crc5  <= 5'h1F;
            crc16 <= 16'hFFFF;
        end else if (bytes.byte_en) begin
            crc5  <= crc5_nxt;
            crc16 <= crc16_nxt;
            if (nbytes == 2'd0)
                tok[7:0] <= bytes.byte_val;
            else if (nbytes == 2'd1)
                tok[`USB_ADDR_W-1:8] <= bytes.byte_val[`USB_ADDR_W-9:0];
        end
        if (bytes.byte_en)
            rp_byte <= bytes.byte_val;
        if (bytes.fin) begin
            rp_pid  <= bytes.pid;
            rp_addr <= tok;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            nbytes     <= '0;
            rp_byte_en <= 1'b0;
            rp_fin     <= 1'b0;
            rp_okay    <= 1'b0;
        end else begin
            rp_byte_en <= bytes.byte_en;
            rp_fin     <= bytes.fin;
            if (bytes.sta)
                nbytes <= '0;
            else if (bytes.byte_en && nbytes != 2'd3)
                nbytes <= nbytes + 1'b1;
            if (bytes.fin)
                rp_okay <= bytes.pid_ok && kind_ok;
        end
    end

endmodule

`default_nettype wire

// File: design/usb_fs_rx_top.sv
// receive only with no handshake replies and CONNECT_CYCLES must be shortened for simulation
`timescale 1ns/10ps
`default_nettype none
`include "usb_fs_defines.svh"

module usb_fs_rx_top import usb_pid_pkg::*; #(
    parameter int CONNECT_CYCLES = `USB_CONNECT_CYCLES_DEFAULT
) (
    input  wire                    clk,         // 60 MHz
    input  wire                    rstn,
    input  wire                    usb_dp_rx,
    input  wire                    usb_dn_rx,
    output logic                   usb_dp_pull, // 1.5k pull-up on D+
    output logic                   usb_rstn,    // low while unplugged or in bus reset
    output usb_pid_t               rp_pid,
    output logic [`USB_ADDR_W-1:0] rp_addr,     // {endpoint, address}
    output logic                   rp_byte_en,
    output logic [7:0]             rp_byte,
    output logic                   rp_fin,
    output logic                   rp_okay
);

    usb_bit_if  bit_bus  ();
    usb_byte_if byte_bus ();

    usb_connect_ctrl #(
        .CONNECT_CYCLES (CONNECT_CYCLES)
    ) connect_i (
        .clk         (clk),
        .rstn        (rstn),
        .usb_dp_rx   (usb_dp_rx),
        .usb_dn_rx   (usb_dn_rx),
        .usb_dp_pull (usb_dp_pull),
        .usb_rstn    (usb_rstn)
    );

    // --------------------------------------------------
    // receive chain held in reset by usb_rstn
    // --------------------------------------------------
    usb_line_rx line_rx_i (
        .clk       (clk),
        .rstn      (usb_rstn),
        .usb_dp_rx (usb_dp_rx),
        .usb_dn_rx (usb_dn_rx),
        .bits      (bit_bus)
    );

    usb_packet_rx packet_rx_i (
        .clk   (clk),
        .rstn  (usb_rstn),
        .bits  (bit_bus),
        .bytes (byte_bus)
    );

    usb_packet_check packet_check_i (
        .clk        (clk),
        .rstn       (usb_rstn),
        .bytes      (byte_bus),
        .rp_pid     (rp_pid),
        .rp_addr    (rp_addr),
        .rp_byte_en (rp_byte_en),
        .rp_byte    (rp_byte),
        .rp_fin     (rp_fin),
        .rp_okay    (rp_okay)
    );

endmodule

`default_nettype wire

// File: tb/usb_fs_rx_checker.sv
// compares at the falling clock edge and expects each packet queued before its first line bit
`timescale 1ns/10ps
`default_nettype none

module usb_fs_rx_checker (
    input  wire        clk,
    input  wire [3:0]  rp_pid,
    input  wire [10:0] rp_addr,
    input  wire        rp_byte_en,
    input  wire [7:0]  rp_byte,
    input  wire        rp_fin,
    input  wire        rp_okay,
    input  wire        usb_dp_pull,
    input  wire        usb_rstn,
    input  wire        lvl_chk,        // compare the link levels this cycle
    input  wire [1:0]  lvl_exp,        // {usb_dp_pull, usb_rstn}
    input  wire        exp_byte_push,
    input  wire [7:0]  exp_byte,
    input  wire        exp_pkt_push,
    input  wire [3:0]  exp_pid,
    input  wire [10:0] exp_addr,
    input  wire        exp_addr_chk,   // only tokens carry an address
    input  wire        exp_okay,
    output int         errors,
    output int         packets
);

    logic [7:0]  byte_q [$];           // bytes still due in the current packet
    logic [16:0] pkt_q [$];            // {addr_chk, okay, addr, pid}
    logic [16:0] e;
    logic [7:0]  b;

    initial begin
        errors  = 0;
        packets = 0;
    end

    task automatic compare_value(input string name, input logic [15:0] exp,
                                 input logic [15:0] act);
        if (exp !== act) begin
            $display("Fail %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    // --------------------------------------------------
    // model queue and comparison
    // --------------------------------------------------
    always @(negedge clk) begin
        if (exp_byte_push)
            byte_q.push_back(exp_byte);
        if (exp_pkt_push)
            pkt_q.push_back({exp_addr_chk, exp_okay, exp_addr, exp_pid});
        if (lvl_chk) begin
            compare_value("usb_dp_pull", 16'(lvl_exp[1]), 16'(usb_dp_pull));
            compare_value("usb_rstn", 16'(lvl_exp[0]), 16'(usb_rstn));
        end
        if (rp_byte_en) begin
            if (byte_q.size() == 0) begin
                $display("byte strobe with rp_byte %h when no byte was expected", rp_byte);
                errors++;
            end else begin
                b = byte_q.pop_front();
                compare_value("rp_byte", 16'(b), 16'(rp_byte));
            end
        end
        if (rp_fin) begin
            packets++;
            if (pkt_q.size() == 0) begin
                $display("end of packet seen when no packet was expected");
                errors++;
            end else begin
                e = pkt_q.pop_front();
                compare_value("rp_pid", 16'(e[3:0]), 16'(rp_pid));
                compare_value("rp_okay", 16'(e[15]), 16'(rp_okay));
                if (e[16])
                    compare_value("rp_addr", 16'(e[14:4]), 16'(rp_addr));
                if (byte_q.size() != 0) begin
                    $display("%0d expected bytes never arrived before end of packet",
                             byte_q.size());
                    errors++;
                    byte_q.delete();
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/usb_fs_rx_tb.sv
// line driven from a 5 clock bit time with no jitter and one packet in flight at a time
`timescale 1ns/10ps
`default_nettype none
`include "usb_fs_defines.svh"

module usb_fs_rx_tb import usb_pid_pkg::*; ();

    logic        clk;
    logic        rstn;
    logic        usb_dp_rx;
    logic        usb_dn_rx;
    logic        usb_dp_pull;
    logic        usb_rstn;
    usb_pid_t    rp_pid;
    logic [10:0] rp_addr;
    logic        rp_byte_en;
    logic [7:0]  rp_byte;
    logic        rp_fin;
    logic        rp_okay;
    logic        lvl_chk;
    logic [1:0]  lvl_exp;
    logic        exp_byte_push;
    logic [7:0]  exp_byte;
    logic        exp_pkt_push;
    logic [3:0]  exp_pid;
    logic [10:0] exp_addr;
    logic        exp_addr_chk;
    logic        exp_okay;
    int          errors;
    int          packets;
    int          timeouts;
    int          err_mark;       // error total at the start of a test
    integer      seed;
    logic [7:0]  pkt [0:19];     // pid byte then payload and crc
    int          pkt_len;

    usb_fs_rx_top #(
        .CONNECT_CYCLES (200)
    ) dut_i (
        .clk         (clk),
        .rstn        (rstn),
        .usb_dp_rx   (usb_dp_rx),
        .usb_dn_rx   (usb_dn_rx),
        .usb_dp_pull (usb_dp_pull),
        .usb_rstn    (usb_rstn),
        .rp_pid      (rp_pid),
        .rp_addr     (rp_addr),
        .rp_byte_en  (rp_byte_en),
        .rp_byte     (rp_byte),
        .rp_fin      (rp_fin),
        .rp_okay     (rp_okay)
    );

    usb_fs_rx_checker check_i (
        .clk (clk), .rp_pid (rp_pid), .rp_addr (rp_addr), .rp_byte_en (rp_byte_en),
        .rp_byte (rp_byte), .rp_fin (rp_fin), .rp_okay (rp_okay),
        .usb_dp_pull (usb_dp_pull), .usb_rstn (usb_rstn),
        .lvl_chk (lvl_chk), .lvl_exp (lvl_exp),
        .exp_byte_push (exp_byte_push), .exp_byte (exp_byte),
        .exp_pkt_push (exp_pkt_push), .exp_pid (exp_pid), .exp_addr (exp_addr),
        .exp_addr_chk (exp_addr_chk), .exp_okay (exp_okay),
        .errors (errors), .packets (packets)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                         // 100 MHz stands in for 60 MHz
    end

    // --------------------------------------------------
    // packet building
    // --------------------------------------------------
    function automatic logic [3:0] token_pid(input logic [1:0] k);
        case (k)
            2'd0:    return PID_OUT;
            2'd1:    return PID_IN;
            2'd2:    return PID_SOF;
            default: return PID_SETUP;
        endcase
    endfunction

    // bit serial crc5 over the 11 bit token field, sent LSB first
    function automatic logic [4:0] crc5_field(input logic [10:0] f);
        logic [4:0] c;
        logic       fb;
        int         i;
        c = 5'h1F;
        for (i = 0; i < 11; i++) begin
            fb = c[4] ^ f[i];
            c  = {c[3:0], 1'b0} ^ (fb ? `USB_CRC5_POLY : 5'h00);
        end
        return ~c;
    endfunction

    function automatic logic [15:0] crc16_payload();
        logic [15:0] c;
        logic        fb;
        int          b;
        int          i;
        c = 16'hFFFF;
        for (b = 1; b < pkt_len; b++) begin
            for (i = 0; i < 8; i++) begin
                fb = c[15] ^ pkt[b][i];
                c  = {c[14:0], 1'b0} ^ (fb ? `USB_CRC16_POLY : 16'h0000);
            end
        end
        return ~c;
    endfunction

    task automatic build_token(input logic [3:0] pid, input logic [10:0] field);
        logic [4:0] crc;
        crc     = crc5_field(field);
        pkt[0]  = {~pid, pid};
        pkt[1]  = field[7:0];
        pkt[2]  = {crc[0], crc[1], crc[2], crc[3], crc[4], field[10:8]};  // crc MSB first
        pkt_len = 3;
    endtask

    task automatic build_data(input logic [3:0] pid, input int n, input logic all_ff);
        logic [15:0] crc;
        logic [31:0] r;
        int          i;
        pkt[0] = {~pid, pid};
        for (i = 1; i <= n; i++) begin
            r      = $random(seed);
            pkt[i] = (all_ff || r[10:8] == 3'd0) ? 8'hFF : r[7:0];  // ones force stuffing
        end
        pkt_len = n + 1;
        crc     = crc16_payload();
        for (i = 0; i < 8; i++) begin
            pkt[n + 1][i] = crc[15 - i];
            pkt[n + 2][i] = crc[7 - i];
        end
        pkt_len = n + 3;
    endtask

    task automatic flip_one_bit();
        logic [31:0] r;
        int          idx;
        int          pos;
        r   = $random(seed);
        idx = r[15:0] % pkt_len;
        pos = (idx == 0) ? 4 + r[17:16] : r[18:16];   // pid byte only in its complement
        pkt[idx][pos] = ~pkt[idx][pos];
    endtask

    // --------------------------------------------------
    // line driver
    // --------------------------------------------------
    task automatic drive_line(input logic dp, input logic dn, input int clocks);
        @(posedge clk);
        #1;
        usb_dp_rx = dp;
        usb_dn_rx = dn;
        repeat (clocks - 1) @(posedge clk);
    endtask

    task automatic drive_packet();
        logic raw [0:167];                             // sync plus up to 20 bytes
        logic lvl;                                     // 1 while at J
        int   n;
        int   b;
        int   i;
        int   ones;
        n = 0;
        for (i = 0; i < 8; i++) begin
            raw[n] = (i == 7);                         // sync is seven zeros then a one
            n++;
        end
        for (b = 0; b < pkt_len; b++) begin
            for (i = 0; i < 8; i++) begin
                raw[n] = pkt[b][i];
                n++;
            end
        end
        lvl  = 1'b1;
        ones = 0;
        for (i = 0; i < n; i++) begin
            if (!raw[i])
                lvl = ~lvl;                            // nrzi zero toggles the line
            drive_line(lvl, ~lvl, `USB_CLKS_PER_BIT);
            ones = raw[i] ? ones + 1 : 0;
            if (ones == 6) begin
                lvl  = ~lvl;                           // stuffed zero
                drive_line(lvl, ~lvl, `USB_CLKS_PER_BIT);
                ones = 0;
            end
        end
        drive_line(1'b0, 1'b0, 2 * `USB_CLKS_PER_BIT);  // eop
        drive_line(1'b1, 1'b0, 2 * `USB_CLKS_PER_BIT);  // idle J
    endtask

    // --------------------------------------------------
    // model hand-off and waits
    // --------------------------------------------------
    task automatic push_expect(input logic okay);
        int i;
        for (i = 1; i < pkt_len; i++) begin
            @(posedge clk);
            #1;
            exp_byte      = pkt[i];
            exp_byte_push = 1'b1;
        end
        @(posedge clk);
        #1;
        exp_byte_push = 1'b0;
        exp_pid       = pkt[0][3:0];
        exp_okay      = okay;
        exp_addr_chk  = (usb_pkt_kind_t'(pkt[0][1:0]) == PKT_TOKEN);
        exp_addr      = exp_addr_chk ? {pkt[2][2:0], pkt[1]} : 11'h000;
        exp_pkt_push  = 1'b1;
        @(posedge clk);
        #1;
        exp_pkt_push  = 1'b0;
    endtask

    task automatic wait_packet(input int start);
        int t;
        t = 0;
        while (packets == start && t < 400) begin
            @(negedge clk);
            t++;
        end
        if (packets == start) begin
            $display("timeout: the DUT gave no end of packet within %0d cycles", t);
            timeouts++;
        end
    endtask

    task automatic run_packet(input logic okay);
        int start;
        push_expect(okay);
        start = packets;
        drive_packet();
        wait_packet(start);
    endtask

    task automatic send_handshake(input logic [3:0] pid);
        pkt[0]  = {~pid, pid};
        pkt_len = 1;
        run_packet(1'b1);
    endtask

    task automatic end_test(input string name);
        int total;
        total = errors + timeouts;
        $display("test %0s done with %0d errors", name, total - err_mark);
        err_mark = total;
    endtask

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin
        logic [31:0] r;
        int          k;
        int          t;
        seed          = 32'h104c;
        timeouts      = 0;
        err_mark      = 0;
        rstn          = 1'b0;
        usb_dp_rx     = 1'b1;                          // J while unplugged
        usb_dn_rx     = 1'b0;
        lvl_chk       = 1'b0;
        lvl_exp       = 2'b00;
        exp_byte_push = 1'b0;
        exp_byte      = 8'h00;
        exp_pkt_push  = 1'b0;
        exp_pid       = 4'h0;
        exp_addr      = 11'h000;
        exp_addr_chk  = 1'b0;
        exp_okay      = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rstn    = 1'b1;
        lvl_chk = 1'b1;                                // both low through the delay
        repeat (200) @(posedge clk);
        #1;
        lvl_chk = 1'b0;
        t = 0;
        while (!(usb_dp_pull && usb_rstn) && t < 10) begin
            @(negedge clk);
            t++;
        end
        if (!(usb_dp_pull && usb_rstn)) begin
            $display("timeout: pull-up and usb_rstn still low 210 cycles after reset");
            timeouts++;
        end
        end_test("connect");

        for (k = 0; k < 20; k++) begin
            r = $random(seed);
            build_token(token_pid(r[1:0]), r[12:2]);
            run_packet(1'b1);
        end
        end_test("tokens");

        for (k = 0; k < 20; k++) begin
            r = $random(seed);
            build_data(r[0] ? PID_DATA1 : PID_DATA0, r[8:4] % 17, k % 4 == 1);
            run_packet(1'b1);
        end
        end_test("data");

        send_handshake(PID_ACK);
        send_handshake(PID_NAK);
        send_handshake(PID_STALL);
        end_test("handshakes");

        for (k = 0; k < 20; k++) begin
            r = $random(seed);
            if (k % 2 == 0)
                build_token(token_pid(r[1:0]), r[12:2]);
            else
                build_data(r[0] ? PID_DATA1 : PID_DATA0, r[8:4] % 17, 1'b0);
            flip_one_bit();
            run_packet(1'b0);
        end
        end_test("corruption");

        drive_line(1'b0, 1'b0, 400);                   // host holds se0
        @(posedge clk);
        #1;
        lvl_exp = 2'b10;                               // pull-up on, device in bus reset
        lvl_chk = 1'b1;
        @(posedge clk);
        #1;
        lvl_chk = 1'b0;
        drive_line(1'b1, 1'b0, 1);
        t = 0;
        while (!usb_rstn && t < 20) begin
            @(negedge clk);
            t++;
        end
        if (!usb_rstn) begin
            $display("timeout: usb_rstn did not return high after J resumed");
            timeouts++;
        end
        r = $random(seed);
        build_token(token_pid(r[1:0]), r[12:2]);
        run_packet(1'b1);
        end_test("bus reset");

        $display("%0d packets, %0d checker errors, %0d timeouts", packets, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+design
design/usb_pid_pkg.sv
design/usb_line_pkg.sv
design/usb_bit_if.sv
design/usb_byte_if.sv
design/usb_connect_ctrl.sv
design/usb_line_rx.sv
design/usb_packet_rx.sv
design/usb_packet_check.sv
design/usb_fs_rx_top.sv
tb/usb_fs_rx_checker.sv
tb/usb_fs_rx_tb.sv
